//--- hdl/lsu_cfg.svh
// build-time sizes of the load-store unit, included by every RTL file and the testbench
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// queue depths, both powers of two
`define LSU_SQ_DEPTH 8
`define LSU_LQ_DEPTH 8

// physical address and data width
`define LSU_XLEN 64

// cache requests that may be outstanding at once
`define LSU_MEM_CREDITS 4

`endif

//--- hdl/lsu_pkg.sv
// shared types and helpers of the load-store unit, imported by the queues, arbiter and top
`default_nettype none
`include "lsu_cfg.svh"

package lsu_pkg;

    localparam int SQ_IDX_W  = $clog2(`LSU_SQ_DEPTH);
    localparam int LQ_IDX_W  = $clog2(`LSU_LQ_DEPTH);
    localparam int TAG_IDX_W = (SQ_IDX_W > LQ_IDX_W) ? SQ_IDX_W : LQ_IDX_W;

    typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_D} mem_size_t;

    typedef logic [SQ_IDX_W:0] sq_ptr_t; // top bit is the wrap flag
    typedef logic [LQ_IDX_W:0] lq_ptr_t;

    typedef struct packed {
        logic                 is_store;
        logic [TAG_IDX_W-1:0] idx;
    } mem_tag_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] data; // already shifted into its lane
        logic [7:0]           strb;
    } store_entry_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
        mem_size_t            size;
        logic                 is_unsigned;
        logic [7:0]           strb;
        sq_ptr_t              sq_mark; // store tail seen at arrival
    } load_entry_t;

    function automatic logic [7:0] make_strobe(input mem_size_t size, input logic [2:0] offset);
        logic [7:0] mask;
        case (size)
            SIZE_B:  mask = 8'h01;
            SIZE_H:  mask = 8'h03;
            SIZE_W:  mask = 8'h0f;
            default: mask = 8'hff;
        endcase
        return mask << offset;
    endfunction

    function automatic logic [`LSU_XLEN-1:0] extend_load(
        input logic [`LSU_XLEN-1:0] dword,
        input logic [2:0]           offset,
        input mem_size_t            size,
        input logic                 is_unsigned
    );
        logic [`LSU_XLEN-1:0] lane;
        lane = dword >> {offset, 3'b000};
        case (size)
            SIZE_B:  return {{(`LSU_XLEN-8){~is_unsigned & lane[7]}}, lane[7:0]};
            SIZE_H:  return {{(`LSU_XLEN-16){~is_unsigned & lane[15]}}, lane[15:0]};
            SIZE_W:  return {{(`LSU_XLEN-32){~is_unsigned & lane[31]}}, lane[31:0]};
            default: return lane;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/entry_ram.sv
// entry payload storage for the store and load queues, one write port and two read ports
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module entry_ram #(
    parameter type payload_t = logic [`LSU_XLEN-1:0],
    parameter int  DEPTH     = `LSU_SQ_DEPTH
) (
    input  wire                     clk,
    input  wire                     we,
    input  wire [$clog2(DEPTH)-1:0] waddr,
    input  wire payload_t           wdata,
    input  wire [$clog2(DEPTH)-1:0] raddr_a,
    output payload_t                rdata_a,
    input  wire [$clog2(DEPTH)-1:0] raddr_b,
    output payload_t                rdata_b
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both reads are combinational
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

endmodule

`default_nettype wire

//--- hdl/store_queue.sv
// store queue: holds stores until commit, drains them in order to the cache, answers load lookups
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module store_queue (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          st_valid,
    input  wire  [`LSU_XLEN-1:0]         st_addr,
    input  wire  [`LSU_XLEN-1:0]         st_data,
    input  wire  lsu_pkg::mem_size_t     st_size,
    input  wire                          st_commit,     // oldest uncommitted store retires
    output logic                         st_credit,
    output logic                         drain_valid,
    output logic [`LSU_XLEN-1:0]         drain_addr,
    output logic [7:0]                   drain_strb,
    output logic [`LSU_XLEN-1:0]         drain_data,
    output lsu_pkg::mem_tag_t            drain_tag,
    input  wire                          drain_grant,
    input  wire                          store_ack,
    input  wire  [lsu_pkg::SQ_IDX_W-1:0] store_ack_idx,
    input  wire  [`LSU_XLEN-1:0]         lookup_addr,
    input  wire  [7:0]                   lookup_strb,
    output logic                         fwd_hit,
    output logic [`LSU_XLEN-1:0]         fwd_data,
    output logic                         overlap,
    output lsu_pkg::sq_ptr_t             sq_head,
    output lsu_pkg::sq_ptr_t             sq_tail
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_SQ_DEPTH;

    sq_ptr_t              head, cmt, tail;      // cmt sits between head and tail
    sq_ptr_t              count;
    logic [SQ_IDX_W-1:0]  head_idx, tail_idx, hit_idx;
    logic [DEPTH-1:0]     requested;            // sent to the cache, ack pending
    logic [`LSU_XLEN-4:0] cam_addr [DEPTH];     // doubleword address for lookup
    logic [7:0]           cam_strb [DEPTH];
    logic                 hit_found;
    logic [7:0]           hit_strb;
    store_entry_t         push_entry, head_entry, hit_entry;

    assign head_idx = head[SQ_IDX_W-1:0];
    assign tail_idx = tail[SQ_IDX_W-1:0];
    assign count    = tail - head;

    always_comb begin
        push_entry.addr = st_addr;
        push_entry.data = st_data << {st_addr[2:0], 3'b000};
        push_entry.strb = make_strobe(st_size, st_addr[2:0]);
    end

    entry_ram #(.payload_t(store_entry_t), .DEPTH(DEPTH)) i_entry_ram (
        .clk     (clk),
        .we      (st_valid),
        .waddr   (tail_idx),
        .wdata   (push_entry),
        .raddr_a (head_idx),
        .rdata_a (head_entry),
        .raddr_b (hit_idx),
        .rdata_b (hit_entry)
    );

    always_ff @(posedge clk) begin
        if (st_valid) begin
            cam_addr[tail_idx] <= st_addr[`LSU_XLEN-1:3];
            cam_strb[tail_idx] <= push_entry.strb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            cmt       <= '0;
            tail      <= '0;
            requested <= '0;
            st_credit <= 1'b0;
        end else begin
            if (st_valid) tail <= tail + 1'b1;
            if (st_commit) cmt <= cmt + 1'b1;
            if (drain_grant) requested[head_idx] <= 1'b1;
            if (store_ack) begin
                requested[store_ack_idx] <= 1'b0;
                head <= head + 1'b1;                    // entry frees after the ack
            end
            st_credit <= store_ack;
        end
    end

    // one store in flight at a time, always the head
    assign drain_valid = (head != cmt) && !requested[head_idx];
    assign drain_addr  = {head_entry.addr[`LSU_XLEN-1:3], 3'b000};
    assign drain_strb  = head_entry.strb;
    assign drain_data  = head_entry.data;
    assign drain_tag   = '{is_store: 1'b1, idx: TAG_IDX_W'(head_idx)};

    // walk from oldest to youngest so the last match wins
    always_comb begin : fwd_scan
        logic [SQ_IDX_W-1:0] idx;
        hit_found = 1'b0;
        hit_idx   = head_idx;
        hit_strb  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = head_idx + SQ_IDX_W'(i);
            if (sq_ptr_t'(i) < count && cam_addr[idx] == lookup_addr[`LSU_XLEN-1:3]
                    && |(cam_strb[idx] & lookup_strb)) begin
                hit_found = 1'b1;
                hit_idx   = idx;
                hit_strb  = cam_strb[idx];
            end
        end
    end

    assign fwd_hit  = hit_found && ((lookup_strb & ~hit_strb) == 8'h00);
    assign overlap  = hit_found && !fwd_hit;       // partial cover, load must wait
    assign fwd_data = hit_entry.data;

    assign sq_head = head;
    assign sq_tail = tail;

    assert property (@(posedge clk) disable iff (rst) st_valid |-> count != sq_ptr_t'(DEPTH))
        else $error("store pushed into a full queue");

    assert property (@(posedge clk) disable iff (rst) store_ack |-> requested[store_ack_idx])
        else $error("store ack for entry %0d that was never sent", store_ack_idx);

endmodule

`default_nettype wire

//--- hdl/load_queue.sv
// load queue: checks loads against queued stores, issues cache reads, returns results in order
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module load_queue (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          ld_valid,
    input  wire  [`LSU_XLEN-1:0]         ld_addr,
    input  wire  lsu_pkg::mem_size_t     ld_size,
    input  wire                          ld_unsigned,
    output logic                         ld_credit,
    output logic [`LSU_XLEN-1:0]         lookup_addr,
    output logic [7:0]                   lookup_strb,
    input  wire                          fwd_hit,
    input  wire  [`LSU_XLEN-1:0]         fwd_data,
    input  wire                          overlap,
    input  wire  lsu_pkg::sq_ptr_t       sq_head,
    input  wire  lsu_pkg::sq_ptr_t       sq_tail,
    output logic                         read_valid,
    output logic [`LSU_XLEN-1:0]         read_addr,
    output lsu_pkg::mem_tag_t            read_tag,
    input  wire                          read_grant,
    input  wire                          load_data_valid,
    input  wire  [lsu_pkg::LQ_IDX_W-1:0] load_data_idx,
    input  wire  [`LSU_XLEN-1:0]         load_data,
    output logic                         ld_result_valid,
    output logic [`LSU_XLEN-1:0]         ld_result_data
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_LQ_DEPTH;

    typedef enum logic [1:0] {LQ_BLOCKED, LQ_READY, LQ_ISSUED, LQ_DONE} lq_state_t;

    lq_ptr_t              head, tail, count;
    logic [LQ_IDX_W-1:0]  head_idx, tail_idx, sel_idx;
    lq_state_t            state [DEPTH];
    logic [DEPTH-1:0]     valid;
    sq_ptr_t              mark [DEPTH];         // store tail at arrival
    logic [`LSU_XLEN-1:0] result [DEPTH];       // extended load value
    logic                 sel_found;
    load_entry_t          push_entry, sel_entry, resp_entry;

    assign head_idx = head[LQ_IDX_W-1:0];
    assign tail_idx = tail[LQ_IDX_W-1:0];
    assign count    = tail - head;

    // the arriving load checks the store queue in the same cycle
    assign lookup_addr = ld_addr;
    assign lookup_strb = make_strobe(ld_size, ld_addr[2:0]);

    always_comb begin
        push_entry.addr        = ld_addr;
        push_entry.size        = ld_size;
        push_entry.is_unsigned = ld_unsigned;
        push_entry.strb        = lookup_strb;
        push_entry.sq_mark     = sq_tail;
    end

    entry_ram #(.payload_t(load_entry_t), .DEPTH(DEPTH)) i_entry_ram (
        .clk     (clk),
        .we      (ld_valid),
        .waddr   (tail_idx),
        .wdata   (push_entry),
        .raddr_a (sel_idx),
        .rdata_a (sel_entry),
        .raddr_b (load_data_idx),
        .rdata_b (resp_entry)
    );

    // youngest first, so the oldest ready entry is picked last
    always_comb begin : ready_scan
        logic [LQ_IDX_W-1:0] idx;
        valid     = '0;
        sel_found = 1'b0;
        sel_idx   = head_idx;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            idx        = head_idx + LQ_IDX_W'(i);
            valid[idx] = lq_ptr_t'(i) < count;
            if (valid[idx] && state[idx] == LQ_READY) begin
                sel_found = 1'b1;
                sel_idx   = idx;
            end
        end
    end

    assign read_valid = sel_found;
    assign read_addr  = {sel_entry.addr[`LSU_XLEN-1:3], 3'b000};
    assign read_tag   = '{is_store: 1'b0, idx: TAG_IDX_W'(sel_idx)};

    assign ld_result_valid = valid[head_idx] && state[head_idx] == LQ_DONE;
    assign ld_result_data  = result[head_idx];
    assign ld_credit       = ld_result_valid;     // slot frees as the result leaves

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < DEPTH; i++) state[i] <= LQ_DONE;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (valid[i] && state[i] == LQ_BLOCKED && sq_head == mark[i])
                    state[i] <= LQ_READY;           // older stores all drained
            end
            if (read_grant) state[sel_idx] <= LQ_ISSUED;
            if (load_data_valid) state[load_data_idx] <= LQ_DONE;
            if (ld_valid) begin
                tail <= tail + 1'b1;
                if (fwd_hit) state[tail_idx] <= LQ_DONE;
                else if (overlap) state[tail_idx] <= LQ_BLOCKED;
                else state[tail_idx] <= LQ_READY;
            end
            if (ld_result_valid) head <= head + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid) mark[tail_idx] <= sq_tail;
        if (ld_valid && fwd_hit)
            result[tail_idx] <= extend_load(fwd_data, ld_addr[2:0], ld_size, ld_unsigned);
        if (load_data_valid)
            result[load_data_idx] <= extend_load(load_data, resp_entry.addr[2:0],
                                                 resp_entry.size, resp_entry.is_unsigned);
    end

    assert property (@(posedge clk) disable iff (rst)
        load_data_valid |-> valid[load_data_idx] && state[load_data_idx] == LQ_ISSUED)
        else $error("cache data for load entry %0d that has no read out", load_data_idx);

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
// cache port arbiter: store drain over load reads, cache credit count, response routing
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module mem_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          drain_valid,
    input  wire  [`LSU_XLEN-1:0]         drain_addr,
    input  wire  [7:0]                   drain_strb,
    input  wire  [`LSU_XLEN-1:0]         drain_data,
    input  wire  lsu_pkg::mem_tag_t      drain_tag,
    output logic                         drain_grant,
    input  wire                          read_valid,
    input  wire  [`LSU_XLEN-1:0]         read_addr,
    input  wire  lsu_pkg::mem_tag_t      read_tag,
    output logic                         read_grant,
    output logic                         mem_req_valid,
    output logic                         mem_req_write,
    output logic [`LSU_XLEN-1:0]         mem_req_addr,
    output logic [7:0]                   mem_req_strb,
    output logic [`LSU_XLEN-1:0]         mem_req_wdata,
    output lsu_pkg::mem_tag_t            mem_req_tag,
    input  wire                          mem_credit,
    input  wire                          mem_resp_valid,
    input  wire  lsu_pkg::mem_tag_t      mem_resp_tag,
    input  wire  [`LSU_XLEN-1:0]         mem_resp_data,
    output logic                         store_ack,
    output logic [lsu_pkg::SQ_IDX_W-1:0] store_ack_idx,
    output logic                         load_data_valid,
    output logic [lsu_pkg::LQ_IDX_W-1:0] load_data_idx,
    output logic [`LSU_XLEN-1:0]         load_data
);
    import lsu_pkg::*;

    localparam int CREDITS = `LSU_MEM_CREDITS;
    localparam int CW      = $clog2(CREDITS + 1);

    logic [CW-1:0] credits;
    logic          can_issue;
    logic          resp_is_store;

    assign can_issue   = credits != '0;
    assign drain_grant = drain_valid && can_issue;
    assign read_grant  = read_valid && can_issue && !drain_valid;  // store first

    assign mem_req_valid = drain_grant || read_grant;
    assign mem_req_write = drain_grant;
    assign mem_req_addr  = drain_grant ? drain_addr : read_addr;
    assign mem_req_strb  = drain_grant ? drain_strb : 8'h00;
    assign mem_req_wdata = drain_grant ? drain_data : '0;
    assign mem_req_tag   = drain_grant ? drain_tag : read_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(CREDITS);
        end else begin
            credits <= credits - CW'(mem_req_valid) + CW'(mem_credit);
        end
    end

    assign resp_is_store   = mem_resp_tag.is_store;
    assign store_ack       = mem_resp_valid && resp_is_store;
    assign load_data_valid = mem_resp_valid && !resp_is_store;
    assign store_ack_idx   = mem_resp_tag.idx[SQ_IDX_W-1:0];
    assign load_data_idx   = mem_resp_tag.idx[LQ_IDX_W-1:0];
    assign load_data       = mem_resp_data;

    assert property (@(posedge clk) disable iff (rst) credits <= CW'(CREDITS))
        else $error("cache credits %0d above the limit", credits);

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
// load-store unit top level, connects store queue, load queue and cache arbiter
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      st_valid,
    input  wire  [`LSU_XLEN-1:0]     st_addr,
    input  wire  [`LSU_XLEN-1:0]     st_data,
    input  wire  lsu_pkg::mem_size_t st_size,
    input  wire                      st_commit,
    output logic                     st_credit,
    input  wire                      ld_valid,
    input  wire  [`LSU_XLEN-1:0]     ld_addr,
    input  wire  lsu_pkg::mem_size_t ld_size,
    input  wire                      ld_unsigned,
    output logic                     ld_credit,
    output logic                     ld_result_valid,
    output logic [`LSU_XLEN-1:0]     ld_result_data,
    output logic                     mem_req_valid,
    output logic                     mem_req_write,
    output logic [`LSU_XLEN-1:0]     mem_req_addr,
    output logic [7:0]               mem_req_strb,
    output logic [`LSU_XLEN-1:0]     mem_req_wdata,
    output lsu_pkg::mem_tag_t        mem_req_tag,
    input  wire                      mem_credit,
    input  wire                      mem_resp_valid,
    input  wire  lsu_pkg::mem_tag_t  mem_resp_tag,
    input  wire  [`LSU_XLEN-1:0]     mem_resp_data
);
    import lsu_pkg::*;

    logic                 drain_valid, drain_grant, read_valid, read_grant;
    logic [`LSU_XLEN-1:0] drain_addr, drain_data, read_addr;
    logic [7:0]           drain_strb, lookup_strb;
    mem_tag_t             drain_tag, read_tag;
    logic                 store_ack, load_data_valid;
    logic [SQ_IDX_W-1:0]  store_ack_idx;
    logic [LQ_IDX_W-1:0]  load_data_idx;
    logic [`LSU_XLEN-1:0] load_data, lookup_addr, fwd_data;
    logic                 fwd_hit, overlap;
    sq_ptr_t              sq_head, sq_tail;

    store_queue i_store_queue (.*);

    load_queue i_load_queue (.*);

    mem_arbiter i_mem_arbiter (.*);

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// testbench clock and reset source, 100 ns period with reset held for the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0; // released on the edge like any other input
    end

endmodule

`default_nettype wire

//--- verification/tb_lsu.sv
// testbench top for lsu_top with core and cache models, shadow memory and checks, run by make test
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module tb_lsu;
    import lsu_pkg::*;

    localparam logic [63:0] BASE = 64'h0000_0000_8000_1000;
    localparam int REGION   = 64;            // bytes of memory under test
    localparam int OP_COUNT = 330;           // directed plus random
    localparam int TIMEOUT  = 2 * OP_COUNT * 40;

    logic clk, rst;
    logic st_valid, st_commit, st_credit, ld_valid, ld_unsigned, ld_credit;
    logic [63:0] st_addr, st_data, ld_addr, ld_result_data;
    mem_size_t st_size, ld_size;
    logic ld_result_valid, mem_req_valid, mem_req_write, mem_credit, mem_resp_valid;
    logic [63:0] mem_req_addr, mem_req_wdata, mem_resp_data;
    logic [7:0] mem_req_strb;
    mem_tag_t mem_req_tag, mem_resp_tag;

    int seed = 32'hb7ea_25b2;
    int errors, checks, cycles;
    int st_spent, st_returned, ld_spent, ld_returned;
    int loads_accepted, results_seen, commits_done, writes_seen, cache_credits;
    logic [7:0] shadow [REGION];
    logic [7:0] cache_mem [REGION];
    logic [63:0] exp_load [$];
    logic [63:0] exp_waddr [$];
    logic [63:0] exp_wdata [$];
    logic [7:0] exp_wstrb [$];
    int commit_wait [$];                     // older loads each store waits for

    logic [3:0] pend_valid;
    mem_tag_t pend_tag [4];
    logic [63:0] pend_data [4];
    int pend_delay [4];
    logic credit_due;

    tb_clock i_tb_clock (.clk(clk), .rst(rst));

    lsu_top i_lsu_top (.*);

    function automatic logic [7:0] fill_byte(input logic [63:0] a);
        return a[7:0] ^ {a[4:0], a[7:5]} ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32]
               ^ a[47:40] ^ a[55:48] ^ a[63:56] ^ 8'h5a;
    endfunction

    function automatic logic [63:0] load_value(input int off, input int n, input bit uns);
        logic [63:0] v;
        v = '0;
        for (int b = 0; b < n; b++) v[8*b +: 8] = shadow[off + b];
        if (!uns && v[8*n-1]) begin
            for (int b = n; b < 8; b++) v[8*b +: 8] = 8'hff;  // sign fill
        end
        return v;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        st_valid <= 1'b0;
        ld_valid <= 1'b0;
    endtask

    task automatic issue_store(input int off, input int sz, input logic [63:0] data);
        int n;
        logic [63:0] lane;
        logic [7:0] strb;
        n = 1 << sz;
        lane = '0;
        while (st_spent - st_returned >= `LSU_SQ_DEPTH) idle_cycle();
        @(posedge clk);
        st_valid <= 1'b1;
        ld_valid <= 1'b0;
        st_addr  <= BASE + 64'(off);
        st_size  <= mem_size_t'(sz);
        st_data  <= data;
        st_spent++;
        strb = 8'((1 << n) - 1) << (off % 8);
        for (int b = 0; b < n; b++) begin
            shadow[off + b] = data[8*b +: 8];
            lane[8*((off % 8) + b) +: 8] = data[8*b +: 8];
        end
        exp_waddr.push_back(BASE + 64'(off - off % 8));
        exp_wstrb.push_back(strb);
        exp_wdata.push_back(lane);
    endtask

    task automatic issue_load(input int off, input int sz, input bit uns);
        while (ld_spent - ld_returned >= `LSU_LQ_DEPTH) idle_cycle();
        @(posedge clk);
        ld_valid    <= 1'b1;
        st_valid    <= 1'b0;
        ld_addr     <= BASE + 64'(off);
        ld_size     <= mem_size_t'(sz);
        ld_unsigned <= uns;
        ld_spent++;
        exp_load.push_back(load_value(off, 1 << sz, uns));
    endtask

    // commits stores in order after older loads return and checks results and credits
    always @(posedge clk) begin : core_model
        if (rst) begin
            st_commit <= 1'b0;
        end else begin
            st_commit <= 1'b0;
            if (ld_valid) loads_accepted++;
            if (st_valid) commit_wait.push_back(loads_accepted);
            if (ld_result_valid) begin
                checks++;
                assert (exp_load.size() > 0) else begin
                    errors++;
                    $display("a load result came out with no load outstanding");
                end
                if (exp_load.size() > 0) begin
                    assert (ld_result_data == exp_load[0]) else begin
                        errors++;
                        $display("[ERROR] ld_result_data got %h expected %h",
                                 ld_result_data, exp_load[0]);
                    end
                    void'(exp_load.pop_front());
                end
                results_seen++;
            end
            if (ld_credit) ld_returned++;
            if (st_credit) st_returned++;
            assert (st_returned <= st_spent && ld_returned <= ld_spent) else begin
                errors++;
                $display("more issue credits came back than were spent");
            end
            assert (ld_returned <= results_seen && st_returned <= writes_seen) else begin
                errors++;
                $display("an issue credit came back before its entry was freed");
            end
            if (commit_wait.size() > 0 && results_seen >= commit_wait[0]) begin
                st_commit <= 1'b1;
                void'(commit_wait.pop_front());
            end
        end
    end

    // cache model answers up to 4 requests in random order after random delays
    always @(posedge clk) begin : cache_model
        int start, slot, idx;
        bit fired;
        if (rst) begin
            mem_resp_valid <= 1'b0;
            mem_credit     <= 1'b0;
            mem_resp_data  <= '0;
            mem_resp_tag   <= '0;
            pend_valid     = '0;
            credit_due     = 1'b0;
            cache_credits  = `LSU_MEM_CREDITS;
        end else begin
            mem_resp_valid <= 1'b0;
            mem_credit     <= credit_due;       // one cycle after the answer
            credit_due     = 1'b0;
            fired          = 1'b0;
            start          = $unsigned($random(seed)) % 4;
            for (int k = 0; k < 4; k++) begin
                slot = (start + k) % 4;
                if (pend_valid[slot] && pend_delay[slot] == 0 && !fired) begin
                    mem_resp_valid   <= 1'b1;
                    mem_resp_tag     <= pend_tag[slot];
                    mem_resp_data    <= pend_data[slot];
                    pend_valid[slot] = 1'b0;
                    fired            = 1'b1;
                    credit_due       = 1'b1;
                end else if (pend_valid[slot] && pend_delay[slot] > 0) begin
                    pend_delay[slot]--;
                end
            end
            if (mem_req_valid) begin
                assert (cache_credits > 0) else begin
                    errors++;
                    $display("cache request sent with no cache credit left");
                end
                cache_credits--;
                slot = -1;
                for (int k = 3; k >= 0; k--) if (!pend_valid[k]) slot = k;
                idx = int'(mem_req_addr - BASE);
                if (mem_req_write) begin
                    checks++;
                    assert (writes_seen < commits_done && exp_waddr.size() > 0) else begin
                        errors++;
                        $display("cache write seen for a store that was not committed");
                    end
                    if (exp_waddr.size() > 0) begin
                        assert (mem_req_addr == exp_waddr[0] && mem_req_strb == exp_wstrb[0])
                        else begin
                            errors++;
                            $display("[ERROR] mem_req_addr/strb got %h/%h expected %h/%h",
                                     mem_req_addr, mem_req_strb, exp_waddr[0], exp_wstrb[0]);
                        end
                        for (int b = 0; b < 8; b++) begin
                            assert (!exp_wstrb[0][b] ||
                                    mem_req_wdata[8*b +: 8] == exp_wdata[0][8*b +: 8])
                            else begin
                                errors++;
                                $display("[ERROR] mem_req_wdata got %h expected %h",
                                         mem_req_wdata, exp_wdata[0]);
                            end
                        end
                        void'(exp_waddr.pop_front());
                        void'(exp_wstrb.pop_front());
                        void'(exp_wdata.pop_front());
                    end
                    writes_seen++;
                    for (int b = 0; b < 8; b++)
                        if (mem_req_strb[b]) cache_mem[idx + b] = mem_req_wdata[8*b +: 8];
                end
                if (slot < 0) begin
                    errors++;
                    $display("cache request arrived with every slot busy");
                end else begin
                    pend_valid[slot] = 1'b1;
                    pend_tag[slot]   = mem_req_tag;
                    pend_delay[slot] = $unsigned($random(seed)) % 8;
                    for (int b = 0; b < 8; b++) pend_data[slot][8*b +: 8] = cache_mem[idx + b];
                end
            end
            if (mem_credit) cache_credits++;    // usable from the next request on
            if (st_commit) commits_done++;      // its write may follow from the next cycle
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int r, sz, off;
        st_valid    = 1'b0;
        st_addr     = '0;
        st_data     = '0;
        st_size     = SIZE_B;
        st_commit   = 1'b0;
        ld_valid    = 1'b0;
        ld_addr     = '0;
        ld_size     = SIZE_B;
        ld_unsigned = 1'b0;
        mem_credit  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_tag   = '0;
        mem_resp_data  = '0;
        for (int a = 0; a < REGION; a++) begin
            shadow[a]    = fill_byte(BASE + 64'(a));
            cache_mem[a] = fill_byte(BASE + 64'(a));
        end
        @(negedge rst);
        issue_load(0, 3, 1'b0);                          // nothing queued
        issue_store(8, 3, 64'h8899_aabb_ccdd_eeff);
        issue_load(12, 2, 1'b0);                         // full forward
        issue_load(8, 1, 1'b1);
        issue_load(14, 1, 1'b0);
        issue_store(16, 0, 64'h0000_0000_0000_00a5);
        issue_load(16, 3, 1'b0);                         // partial overlap blocks the load
        issue_load(24, 2, 1'b1);
        for (int s = 0; s < 4; s++) begin
            issue_store(32 + 8*s, s, 64'hf1e2_d3c4_b5a6_9788);
            issue_load(32 + 8*s, s, 1'b0);
            issue_load(32 + 8*s, s, 1'b1);
            issue_load(40, s, 1'b1);
        end
        repeat (4) idle_cycle();
        for (int i = 0; i < 300; i++) begin
            r   = $random(seed);
            sz  = $unsigned($random(seed)) % 4;
            off = ($unsigned($random(seed)) % REGION) & ~((1 << sz) - 1);
            if (r[0]) issue_store(off, sz, {$random(seed), $random(seed)});
            else issue_load(off, sz, r[1]);
        end
        idle_cycle();
        while (exp_load.size() > 0 || st_returned != st_spent || ld_returned != ld_spent
               || cache_credits != `LSU_MEM_CREDITS || pend_valid != '0) idle_cycle();
        repeat (3) idle_cycle();
        for (int a = 0; a < REGION; a++) begin
            assert (cache_mem[a] == shadow[a]) else begin
                errors++;
                $display("[ERROR] cache_mem[%h] got %h expected %h", a, cache_mem[a], shadow[a]);
            end
        end
        $display("checks %0d, errors %0d, loads %0d, stores %0d, cycles %0d",
                 checks, errors, ld_spent, st_spent, cycles);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/entry_ram.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/mem_arbiter.sv
hdl/lsu_top.sv
verification/tb_clock.sv
verification/tb_lsu.sv

//--- Makefile
# Verilator build and run of the load-store unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, check $(LOG) for the pass line"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_lsu -o sim_lsu
	./obj_dir/sim_lsu | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
